/* src.f */
hdl/st506_pkg.sv
hdl/st506_regs.sv
hdl/st506_seek_ctrl.sv
hdl/st506_cyl_track.sv
hdl/st506_cable.sv
hdl/st506_hdd_top.sv
verification/st506_drive_model.sv
verification/st506_hdd_props.sv
verification/tb_st506_hdd.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_st506_hdd
FILELIST  := src.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := obj_dir/V$(TOP)
LOG     := sim.log

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@! grep -q "TEST RESULT: FAIL" $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/tb_st506_hdd.sv */
//----------------------------------------------------------
// ST-506 controller testbench
// Register access, seek, recalibrate, second drive and
// error cases against a two-drive cable model
//----------------------------------------------------------
`default_nettype none

module tb_st506_hdd;
    localparam int CYCLE_LIMIT = 20000;         // All tests need under 2500 cycles

    logic        clk_200mhz, reset_n, wb_cyc, wb_stb, wb_we;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_w, wb_dat_r, rd;
    logic        wb_ack, irq_hdd, hdd_busy, hdd_error;
    logic [3:0]  head_sel_n;
    logic        step_n, dir_n, ds0_n, ds1_n, sc_n, t0_n, rdy_n, suppress;
    logic [15:0] cur_cyl;
    int          errors = 0, checks = 0, cycles = 0;
    int          steps_in, steps_out, irqs, ds0_low, ds1_low;
    logic        step_prev = 1'b1, err_seen, busy_seen;

    st506_hdd_top #(.SEEK_TIMEOUT(200), .MAX_RECAL_STEPS(64)) dut (
        .clk_200mhz, .reset_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_dat_r, .wb_ack, .irq_hdd, .st506_head_sel_n(head_sel_n),
        .st506_step_n(step_n), .st506_dir_n(dir_n), .st506_ds0_n(ds0_n),
        .st506_ds1_n(ds1_n), .st506_seek_complete_n(sc_n), .st506_track00_n(t0_n),
        .st506_write_fault_n(1'b1), .st506_index_n(1'b1), .st506_ready_n(rdy_n),
        .hdd_current_cylinder(cur_cyl), .hdd_busy, .hdd_error
    );

    st506_drive_model u_drives (
        .clk_200mhz, .st506_step_n(step_n), .st506_dir_n(dir_n), .st506_ds0_n(ds0_n),
        .st506_ds1_n(ds1_n), .suppress_complete(suppress), .st506_seek_complete_n(sc_n),
        .st506_track00_n(t0_n), .st506_ready_n(rdy_n)
    );

    initial begin
        clk_200mhz = 1'b0;
        forever #2 clk_200mhz = ~clk_200mhz;
    end

    // Cable and interrupt monitor, sampled mid-cycle
    always @(negedge clk_200mhz) begin
        if (step_prev && !step_n) begin
            if (dir_n) steps_out++;
            else steps_in++;
        end
        step_prev = step_n;
        if (irq_hdd) irqs++;
        if (hdd_error) err_seen = 1'b1;
        if (hdd_busy) busy_seen = 1'b1;
        if (!ds0_n) ds0_low++;
        if (!ds1_n) ds1_low++;
    end

    always @(posedge clk_200mhz) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped: no progress within %0d cycles", CYCLE_LIMIT);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // One Wishbone classic cycle, held through the ack cycle
    task automatic bus_cycle(input logic we, input logic [7:0] adr,
                             input logic [31:0] data, output logic [31:0] rdata);
        @(negedge clk_200mhz);
        {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = {1'b1, 1'b1, we, adr, data};
        do @(negedge clk_200mhz); while (!wb_ack);
        rdata = wb_dat_r;
        @(negedge clk_200mhz);
        {wb_cyc, wb_stb, wb_we} = 3'b000;
    endtask

    task automatic reg_write(input logic [7:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic reg_read(input logic [7:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    // Issue a command and wait for the interrupt
    task automatic run_cmd(input logic [7:0] adr, input logic [31:0] cmd);
        {steps_in, steps_out, irqs, ds0_low, ds1_low} = '0;
        err_seen = 1'b0;
        busy_seen = 1'b0;
        reg_write(adr, cmd);
        do @(negedge clk_200mhz); while (!irq_hdd);
        repeat (3) @(negedge clk_200mhz);
    endtask

    initial begin
        {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w, suppress} = '0;
        reset_n = 1'b0;
        repeat (8) @(posedge clk_200mhz);
        @(negedge clk_200mhz);
        reset_n = 1'b1;
        // Register readback and unmapped space
        reg_write(8'h18, 32'd12);
        reg_read(8'h18, rd);
        check_value("TARGET0", rd, 32'd12);
        reg_write(8'h04, 32'h0000_1E08);       // Period 30, width 8
        reg_read(8'h04, rd);
        check_value("TIMING", rd, 32'h0000_1E08);
        reg_read(8'h08, rd);
        check_value("unmapped", rd, 32'h0);
        // Drive 0 seek inward to 12
        reg_write(8'h00, 32'h0003_0000);
        run_cmd(8'h14, 32'h1);
        check_value("steps_in", steps_in, 12);
        check_value("steps_out", steps_out, 0);
        check_value("irq_pulses", irqs, 1);
        check_value("hdd_busy_seen", busy_seen, 1);
        check_value("hdd_busy", hdd_busy, 0);
        check_value("hdd_current_cylinder", cur_cyl, 12);
        reg_read(8'h10, rd);
        check_value("STATUS0.cyl", rd[31:16], 12);
        check_value("STATUS0.done", rd[9], 1);
        // Recalibrate drive 0
        run_cmd(8'h14, 32'h2);
        check_value("steps_out", steps_out, 12);
        check_value("hdd_current_cylinder", cur_cyl, 0);
        reg_read(8'h10, rd);
        check_value("STATUS0.cyl", rd[31:16], 0);
        check_value("STATUS0.track00", rd[2], 1);
        // Drive 1 seek to 5 on head 10
        reg_write(8'h00, 32'h0003_0100);
        reg_write(8'h38, 32'd5);
        run_cmd(8'h34, 32'hA1);
        check_value("steps_in", steps_in, 5);
        check_value("st506_head_sel_n", head_sel_n, 4'h5);
        check_value("st506_ds1_n", ds1_n, 0);
        check_value("st506_ds0_n", ds0_n, 1);
        check_value("hdd_current_cylinder", cur_cyl, 5);
        reg_read(8'h30, rd);
        check_value("STATUS1.cyl", rd[31:16], 5);
        check_value("STATUS1.done", rd[9], 1);
        reg_read(8'h10, rd);
        check_value("STATUS0.cyl", rd[31:16], 0);
        // Seek complete held off on drive 0
        reg_write(8'h00, 32'h0003_0000);
        suppress = 1'b1;
        reg_write(8'h18, 32'd3);
        run_cmd(8'h14, 32'h1);
        suppress = 1'b0;
        check_value("hdd_error_seen", err_seen, 1);
        check_value("irq_pulses", irqs, 1);
        reg_read(8'h10, rd);
        check_value("STATUS0.error", rd[10], 1);
        check_value("STATUS0.done", rd[9], 0);
        // Drive 1 selected but disabled
        reg_write(8'h00, 32'h0001_0100);
        reg_write(8'h38, 32'd9);
        run_cmd(8'h34, 32'h1);
        check_value("hdd_error_seen", err_seen, 1);
        check_value("irq_pulses", irqs, 1);
        check_value("ds1_low_cycles", ds1_low, 0);
        check_value("ds0_low_cycles", ds0_low, 0);
        check_value("steps_in", steps_in, 0);
        reg_read(8'h30, rd);
        check_value("STATUS1.error", rd[10], 1);

        // Bound cable and bus properties add their failures
        errors += dut.u_props.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/st506_hdd_props.sv */
//----------------------------------------------------------
// ST-506 controller cable and bus properties
// Step pulse width, drive select exclusivity, Wishbone ack
//----------------------------------------------------------
`default_nettype none

module st506_hdd_props (
    input  wire       clk_200mhz,
    input  wire       reset_n,
    input  wire       st506_step_n,
    input  wire       st506_ds0_n,
    input  wire       st506_ds1_n,
    input  wire [7:0] step_width,
    input  wire       wb_cyc,
    input  wire       wb_stb,
    input  wire       wb_ack
);
    logic [7:0] low_cnt;                        // Length of the current step pulse
    int         fail_count = 0;                 // Failed properties so far

    always_ff @(posedge clk_200mhz or negedge reset_n) begin
        if (!reset_n)
            low_cnt <= '0;
        else
            low_cnt <= st506_step_n ? 8'd0 : low_cnt + 8'd1;
    end

    a_step_width: assert property (@(posedge clk_200mhz) disable iff (!reset_n)
        $rose(st506_step_n) |-> low_cnt == step_width)
        else begin
            $error("step pulse length differs from step width");
            fail_count++;
        end
    a_one_select: assert property (@(posedge clk_200mhz) disable iff (!reset_n)
        !(!st506_ds0_n && !st506_ds1_n))
        else begin
            $error("both drive selects low");
            fail_count++;
        end
    a_step_sel: assert property (@(posedge clk_200mhz) disable iff (!reset_n)
        !st506_step_n |-> (!st506_ds0_n || !st506_ds1_n))
        else begin
            $error("step low with no drive selected");
            fail_count++;
        end
    a_ack_single: assert property (@(posedge clk_200mhz) disable iff (!reset_n)
        wb_ack |=> !wb_ack)
        else begin
            $error("ack longer than one cycle");
            fail_count++;
        end
    a_ack_req: assert property (@(posedge clk_200mhz) disable iff (!reset_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            $error("ack without a request");
            fail_count++;
        end

endmodule

bind st506_hdd_top st506_hdd_props u_props (
    .clk_200mhz, .reset_n, .st506_step_n, .st506_ds0_n, .st506_ds1_n,
    .step_width, .wb_cyc, .wb_stb, .wb_ack
);

`default_nettype wire

/* verification/st506_drive_model.sv */
//----------------------------------------------------------
// ST-506 drive pair model
// Two drives on one daisy-chained control cable. Tracks
// head position, track 0, seek complete and ready
//----------------------------------------------------------
`default_nettype none

module st506_drive_model (
    input  wire  clk_200mhz,
    input  wire  st506_step_n,
    input  wire  st506_dir_n,
    input  wire  st506_ds0_n,
    input  wire  st506_ds1_n,
    input  wire  suppress_complete,             // Holds seek complete off
    output logic st506_seek_complete_n,
    output logic st506_track00_n,
    output logic st506_ready_n
);
    logic [15:0] cyl [2];
    logic        step_d = 1'b1;
    logic [5:0]  quiet = 6'd20;                 // Cycles since the last step

    wire         sel1 = !st506_ds1_n;
    wire         any  = !st506_ds0_n || sel1;
    wire  [15:0] cur  = cyl[sel1];

    initial begin
        cyl[0] = '0;
        cyl[1] = '0;
    end

    always @(posedge clk_200mhz) begin
        step_d <= st506_step_n;
        if (step_d && !st506_step_n && any) begin
            quiet <= '0;                        // Head moves on the falling edge
            if (st506_dir_n) begin
                if (cur != 0)
                    cyl[sel1] <= cur - 16'd1;   // Outward, stops at track 0
            end else begin
                cyl[sel1] <= cur + 16'd1;
            end
        end else if (quiet < 6'd20) begin
            quiet <= quiet + 6'd1;
        end
    end

    assign st506_seek_complete_n = !(any && quiet >= 6'd20 && !suppress_complete);
    assign st506_track00_n       = !(any && cur == 0);
    assign st506_ready_n         = !any;

endmodule

`default_nettype wire

/* hdl/st506_hdd_top.sv */
//----------------------------------------------------------
// ST-506 dual drive controller, top level
// Register file, shared seek sequencer, per-drive position
// trackers and the shared 34-pin control cable
//----------------------------------------------------------
`default_nettype none

module st506_hdd_top #(
    parameter int SEEK_TIMEOUT    = st506_pkg::DEF_SEEK_TIMEOUT,
    parameter int MAX_RECAL_STEPS = st506_pkg::DEF_MAX_RECAL_STEPS
) (
    input  wire              clk_200mhz,
    input  wire              reset_n,
    input  wire              wb_cyc,
    input  wire              wb_stb,
    input  wire              wb_we,
    input  wire  [7:0]       wb_adr,
    input  wire  [31:0]      wb_dat_w,
    output logic [31:0]      wb_dat_r,
    output logic             wb_ack,
    output logic             irq_hdd,
    output logic [3:0]       st506_head_sel_n,
    output logic             st506_step_n,
    output logic             st506_dir_n,
    output logic             st506_ds0_n,
    output logic             st506_ds1_n,
    input  wire              st506_seek_complete_n,
    input  wire              st506_track00_n,
    input  wire              st506_write_fault_n,
    input  wire              st506_index_n,
    input  wire              st506_ready_n,
    output st506_pkg::cyl_t  hdd_current_cylinder,
    output logic             hdd_busy,
    output logic             hdd_error
);
    logic             active_drive, drv0_en, drv1_en;
    st506_pkg::head_t head;
    st506_pkg::cyl_t  target_cyl, cyl0, cyl1;
    logic [7:0]       step_width;
    logic [15:0]      step_period;
    logic             seek_start, recal_start, seek_busy, seek_done, seek_error;
    logic             step_event, step_active, step_out, recal_hit;
    logic             seek_complete, track00, write_fault;
    logic [st506_pkg::DRV_STATUS_W-1:0] drv0_status, drv1_status;

    st506_regs u_regs (
        .clk_200mhz, .reset_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_dat_r, .wb_ack, .seek_busy, .seek_done, .seek_error, .cyl0, .cyl1,
        .drv0_status, .drv1_status, .active_drive, .drv0_en, .drv1_en, .head,
        .target_cyl, .step_width, .step_period, .seek_start, .recal_start,
        .irq(irq_hdd)
    );

    // Sequencer works on whichever drive is active
    st506_seek_ctrl #(
        .SEEK_TIMEOUT(SEEK_TIMEOUT),
        .MAX_RECAL_STEPS(MAX_RECAL_STEPS)
    ) u_seek (
        .clk_200mhz, .reset_n, .seek_start, .recal_start, .target_cyl,
        .current_cyl(hdd_current_cylinder), .step_width, .step_period,
        .seek_complete, .track00, .seek_busy, .seek_done, .seek_error,
        .step_event, .step_active, .step_out, .recal_hit
    );

    st506_cyl_track u_track0 (
        .clk_200mhz, .reset_n, .selected(!active_drive), .step_event, .step_out,
        .recal_hit, .cylinder(cyl0)
    );

    st506_cyl_track u_track1 (
        .clk_200mhz, .reset_n, .selected(active_drive), .step_event, .step_out,
        .recal_hit, .cylinder(cyl1)
    );

    st506_cable u_cable (
        .clk_200mhz, .reset_n, .active_drive, .drv0_en, .drv1_en, .head,
        .step_active, .step_out, .st506_seek_complete_n, .st506_track00_n,
        .st506_write_fault_n, .st506_index_n, .st506_ready_n, .st506_head_sel_n,
        .st506_step_n, .st506_dir_n, .st506_ds0_n, .st506_ds1_n, .seek_complete,
        .track00, .write_fault, .drv0_status, .drv1_status
    );

    assign hdd_current_cylinder = active_drive ? cyl1 : cyl0;
    assign hdd_busy             = seek_busy;
    assign hdd_error            = seek_error || write_fault;   // Seek failure or drive fault

endmodule

`default_nettype wire

/* hdl/st506_cable.sv */
//----------------------------------------------------------
// ST-506 34-pin control cable
// Registered active-low outputs, 2-flop status sync and
// held status for each drive on the daisy chain
//----------------------------------------------------------
`default_nettype none

module st506_cable (
    input  wire                                clk_200mhz,
    input  wire                                reset_n,
    input  wire                                active_drive,
    input  wire                                drv0_en,
    input  wire                                drv1_en,
    input  wire  st506_pkg::head_t             head,
    input  wire                                step_active,
    input  wire                                step_out,
    input  wire                                st506_seek_complete_n,
    input  wire                                st506_track00_n,
    input  wire                                st506_write_fault_n,
    input  wire                                st506_index_n,
    input  wire                                st506_ready_n,
    output logic [3:0]                         st506_head_sel_n,
    output logic                               st506_step_n,
    output logic                               st506_dir_n,
    output logic                               st506_ds0_n,
    output logic                               st506_ds1_n,
    output logic                               seek_complete,
    output logic                               track00,
    output logic                               write_fault,
    output logic [st506_pkg::DRV_STATUS_W-1:0] drv0_status,
    output logic [st506_pkg::DRV_STATUS_W-1:0] drv1_status
);
    logic [4:0] sync1;                              // Raw cable levels, meta stage
    logic [4:0] sync2;

    wire        sel0    = !active_drive && drv0_en;
    wire        sel1    = active_drive && drv1_en;
    wire  [4:0] status  = ~sync2;                   // Active high, bit 0 ready
    wire  [4:0] cable_n = {st506_index_n, st506_write_fault_n, st506_track00_n,
                           st506_seek_complete_n, st506_ready_n};

    always_ff @(posedge clk_200mhz or negedge reset_n) begin
        if (!reset_n) begin
            st506_head_sel_n <= 4'hF;               // All lines released
            st506_step_n     <= 1'b1;
            st506_dir_n      <= 1'b1;
            st506_ds0_n      <= 1'b1;
            st506_ds1_n      <= 1'b1;
            sync1            <= 5'h1F;
            sync2            <= 5'h1F;
            drv0_status      <= '0;
            drv1_status      <= '0;
        end else begin
            st506_head_sel_n <= ~head;
            st506_step_n     <= !(step_active && (sel0 || sel1));   // Only to a selected drive
            st506_dir_n      <= step_out;           // Low = direction in
            st506_ds0_n      <= !sel0;
            st506_ds1_n      <= !sel1;
            sync1            <= cable_n;
            sync2            <= sync1;
            // Status only belongs to the drive currently on the cable
            if (!st506_ds0_n)
                drv0_status <= status;
            if (!st506_ds1_n)
                drv1_status <= status;
        end
    end

    assign seek_complete = status[1];
    assign track00       = status[2];
    assign write_fault   = status[3];

endmodule

`default_nettype wire

/* hdl/st506_cyl_track.sv */
//----------------------------------------------------------
// ST-506 cylinder tracker
// Position of one drive, follows steps while selected
//----------------------------------------------------------
`default_nettype none

module st506_cyl_track (
    input  wire             clk_200mhz,
    input  wire             reset_n,
    input  wire             selected,      // This drive is the active one
    input  wire             step_event,
    input  wire             step_out,      // 1 = toward cylinder 0
    input  wire             recal_hit,
    output st506_pkg::cyl_t cylinder
);

    always_ff @(posedge clk_200mhz or negedge reset_n) begin
        if (!reset_n) begin
            cylinder <= '0;
        end else if (selected) begin
            if (recal_hit) begin
                cylinder <= '0;                         // Reached track 0
            end else if (step_event) begin
                if (!step_out)
                    cylinder <= cylinder + 16'd1;       // Step in
                else if (cylinder != 0)
                    cylinder <= cylinder - 16'd1;       // Step out, clamp at 0
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/st506_seek_ctrl.sv */
//----------------------------------------------------------
// ST-506 seek sequencer
// Shared between both drives. Issues timed step pulses,
// recalibrates to track 0 and times out on seek complete
//----------------------------------------------------------
`default_nettype none

module st506_seek_ctrl #(
    parameter int SEEK_TIMEOUT    = 1_000_000,
    parameter int MAX_RECAL_STEPS = 1024
) (
    input  wire              clk_200mhz,
    input  wire              reset_n,
    input  wire              seek_start,
    input  wire              recal_start,
    input  wire  st506_pkg::cyl_t target_cyl,
    input  wire  st506_pkg::cyl_t current_cyl,
    input  wire  [7:0]       step_width,
    input  wire  [15:0]      step_period,
    input  wire              seek_complete,    // Synchronized, active high
    input  wire              track00,
    output logic             seek_busy,
    output logic             seek_done,
    output logic             seek_error,
    output logic             step_event,
    output logic             step_active,
    output logic             step_out,         // 1 = toward cylinder 0
    output logic             recal_hit
);
    localparam int TO_W = $clog2(SEEK_TIMEOUT + 1);

    typedef enum logic [1:0] {S_IDLE, S_STEP, S_WAIT, S_DONE} state_t;

    state_t          state;
    st506_pkg::cyl_t steps_left;
    logic            is_recal;
    logic            fail;
    logic [7:0]      width_cnt;
    logic [15:0]     period_cnt;
    logic [TO_W-1:0] timeout_cnt;

    always_ff @(posedge clk_200mhz or negedge reset_n) begin
        if (!reset_n) begin
            state       <= S_IDLE;
            steps_left  <= '0;
            is_recal    <= 1'b0;
            fail        <= 1'b0;
            step_out    <= 1'b0;
            step_event  <= 1'b0;
            recal_hit   <= 1'b0;
            width_cnt   <= '0;
            period_cnt  <= '0;
            timeout_cnt <= '0;
        end else begin
            step_event <= 1'b0;
            recal_hit  <= 1'b0;
            if (width_cnt != 0)
                width_cnt <= width_cnt - 8'd1;      // Step pulse runs down
            if (state != S_WAIT)
                timeout_cnt <= '0;
            case (state)
                S_IDLE: begin
                    fail       <= 1'b0;
                    period_cnt <= '0;               // First step right away
                    if (seek_start) begin
                        is_recal   <= 1'b0;
                        step_out   <= target_cyl < current_cyl;
                        steps_left <= (target_cyl > current_cyl) ? target_cyl - current_cyl
                                                                 : current_cyl - target_cyl;
                        state      <= S_STEP;
                    end else if (recal_start) begin
                        is_recal   <= 1'b1;
                        step_out   <= 1'b1;         // Outward to track 0
                        steps_left <= st506_pkg::cyl_t'(MAX_RECAL_STEPS);
                        state      <= S_STEP;
                    end
                end
                S_STEP: begin
                    if (period_cnt != 0) begin
                        period_cnt <= period_cnt - 16'd1;
                    end else if (is_recal && track00) begin
                        recal_hit <= 1'b1;
                        state     <= S_WAIT;
                    end else if (steps_left == 0) begin
                        fail  <= is_recal;          // Recal ran out of steps
                        state <= is_recal ? S_DONE : S_WAIT;
                    end else begin
                        step_event <= 1'b1;
                        width_cnt  <= step_width;
                        period_cnt <= step_period - 16'd1;
                        steps_left <= steps_left - 16'd1;
                    end
                end
                S_WAIT: begin
                    if (seek_complete) begin
                        state <= S_DONE;
                    end else if (timeout_cnt == TO_W'(SEEK_TIMEOUT - 1)) begin
                        fail  <= 1'b1;
                        state <= S_DONE;
                    end else begin
                        timeout_cnt <= timeout_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;           // S_DONE, result pulse
            endcase
        end
    end

    assign seek_busy   = state != S_IDLE;
    assign seek_done   = (state == S_DONE) && !fail;
    assign seek_error  = (state == S_DONE) && fail;
    assign step_active = width_cnt != 0;

endmodule

`default_nettype wire

/* hdl/st506_regs.sv */
//----------------------------------------------------------
// ST-506 register file
// Wishbone classic slave with one wait state, per-drive
// command and target registers, status words and interrupt
//----------------------------------------------------------
`default_nettype none

module st506_regs (
    input  wire                                  clk_200mhz,
    input  wire                                  reset_n,
    input  wire                                  wb_cyc,
    input  wire                                  wb_stb,
    input  wire                                  wb_we,
    input  wire  [7:0]                           wb_adr,
    input  wire  [31:0]                          wb_dat_w,
    output logic [31:0]                          wb_dat_r,
    output logic                                 wb_ack,
    input  wire                                  seek_busy,
    input  wire                                  seek_done,
    input  wire                                  seek_error,
    input  wire  st506_pkg::cyl_t                cyl0,
    input  wire  st506_pkg::cyl_t                cyl1,
    input  wire  [st506_pkg::DRV_STATUS_W-1:0]   drv0_status,
    input  wire  [st506_pkg::DRV_STATUS_W-1:0]   drv1_status,
    output logic                                 active_drive,
    output logic                                 drv0_en,
    output logic                                 drv1_en,
    output st506_pkg::head_t                     head,
    output st506_pkg::cyl_t                      target_cyl,
    output logic [7:0]                           step_width,
    output logic [15:0]                          step_period,
    output logic                                 seek_start,
    output logic                                 recal_start,
    output logic                                 irq
);
    logic [31:0]      timing;
    st506_pkg::cyl_t  target0;
    st506_pkg::cyl_t  target1;
    st506_pkg::head_t head0;
    st506_pkg::head_t head1;
    logic             done0;
    logic             done1;
    logic             err0;
    logic             err1;
    logic [31:0]      rdata;

    wire [5:0] word    = wb_adr[7:2];               // Word address
    wire       wr      = wb_ack && wb_we;           // Write lands on the ack cycle
    wire       cmd0_wr = wr && (word == st506_pkg::ADDR_CMD0);
    wire       cmd1_wr = wr && (word == st506_pkg::ADDR_CMD1);
    wire       cmd_go  = !seek_busy &&
                         ((cmd0_wr && !active_drive) || (cmd1_wr && active_drive));

    function automatic logic [31:0] status_word(input st506_pkg::cyl_t cyl,
                                                input logic busy,
                                                input logic done,
                                                input logic err,
                                                input logic [4:0] drv);
        logic [31:0] w;
        w = '0;
        w[st506_pkg::STAT_CYL_LSB +: 16] = cyl;
        w[st506_pkg::STAT_BUSY]          = busy;
        w[st506_pkg::STAT_DONE]          = done;
        w[st506_pkg::STAT_ERROR]         = err;
        w[4:0]                           = drv;     // Drive lines as held
        return w;
    endfunction

    always_ff @(posedge clk_200mhz or negedge reset_n) begin
        if (!reset_n) begin
            wb_ack       <= 1'b0;
            active_drive <= 1'b0;
            drv0_en      <= 1'b0;
            drv1_en      <= 1'b0;
            timing       <= st506_pkg::TIMING_RESET;
            target0      <= '0;
            target1      <= '0;
            head0        <= '0;
            head1        <= '0;
            {done0, done1, err0, err1} <= '0;
            seek_start   <= 1'b0;
            recal_start  <= 1'b0;
            irq          <= 1'b0;
        end else begin
            wb_ack      <= wb_cyc && wb_stb && !wb_ack;   // One wait state
            seek_start  <= cmd_go && wb_dat_w[st506_pkg::CMD_SEEK];
            recal_start <= cmd_go && wb_dat_w[st506_pkg::CMD_RECAL]
                                  && !wb_dat_w[st506_pkg::CMD_SEEK];   // Seek wins
            irq         <= seek_done || seek_error;
            if (wr) begin
                case (word)
                    st506_pkg::ADDR_CTRL: begin
                        active_drive <= wb_dat_w[st506_pkg::CTRL_DRIVE_SEL];
                        drv0_en      <= wb_dat_w[st506_pkg::CTRL_DRV0_EN];
                        drv1_en      <= wb_dat_w[st506_pkg::CTRL_DRV1_EN];
                    end
                    st506_pkg::ADDR_TIMING:  timing  <= wb_dat_w;
                    st506_pkg::ADDR_CMD0:    head0   <= wb_dat_w[st506_pkg::CMD_HEAD_LSB +: 4];
                    st506_pkg::ADDR_CMD1:    head1   <= wb_dat_w[st506_pkg::CMD_HEAD_LSB +: 4];
                    st506_pkg::ADDR_TARGET0: target0 <= wb_dat_w[15:0];
                    st506_pkg::ADDR_TARGET1: target1 <= wb_dat_w[15:0];
                    default: ;
                endcase
            end
            // Flags cleared by a new command, set by the sequencer result
            if (cmd0_wr)
                {done0, err0} <= 2'b00;
            if (cmd1_wr)
                {done1, err1} <= 2'b00;
            if (seek_done && !active_drive) done0 <= 1'b1;
            if (seek_done &&  active_drive) done1 <= 1'b1;
            if (seek_error && !active_drive) err0 <= 1'b1;
            if (seek_error &&  active_drive) err1 <= 1'b1;
        end
    end

    always_comb begin
        rdata = '0;                                 // Unmapped reads zero
        case (word)
            st506_pkg::ADDR_CTRL: begin
                rdata[st506_pkg::CTRL_DRIVE_SEL] = active_drive;
                rdata[st506_pkg::CTRL_DRV0_EN]   = drv0_en;
                rdata[st506_pkg::CTRL_DRV1_EN]   = drv1_en;
            end
            st506_pkg::ADDR_TIMING:  rdata = timing;
            st506_pkg::ADDR_STATUS0: rdata = status_word(cyl0, seek_busy && !active_drive,
                                                         done0, err0, drv0_status);
            st506_pkg::ADDR_CMD0:    rdata[st506_pkg::CMD_HEAD_LSB +: 4] = head0;
            st506_pkg::ADDR_TARGET0: rdata[15:0] = target0;
            st506_pkg::ADDR_STATUS1: rdata = status_word(cyl1, seek_busy && active_drive,
                                                         done1, err1, drv1_status);
            st506_pkg::ADDR_CMD1:    rdata[st506_pkg::CMD_HEAD_LSB +: 4] = head1;
            st506_pkg::ADDR_TARGET1: rdata[15:0] = target1;
            default: ;
        endcase
    end

    // Read data captured with the ack
    always_ff @(posedge clk_200mhz) begin
        if (wb_cyc && wb_stb && !wb_ack)
            wb_dat_r <= rdata;
    end

    assign head        = active_drive ? head1 : head0;
    assign target_cyl  = active_drive ? target1 : target0;
    assign step_width  = timing[7:0];
    assign step_period = timing[23:8];

endmodule

`default_nettype wire

/* hdl/st506_pkg.sv */
//----------------------------------------------------------
// ST-506 controller shared definitions
// Register map, bit positions, reset values and the
// cylinder and head types used across the design
//----------------------------------------------------------
`default_nettype none

package st506_pkg;

    typedef logic [15:0] cyl_t;                 // Cylinder number
    typedef logic [3:0]  head_t;                // Head number

    localparam int DRV_STATUS_W = 5;            // Held status bits per drive

    // Register word addresses, byte address / 4
    localparam logic [5:0] ADDR_CTRL    = 6'h00;
    localparam logic [5:0] ADDR_TIMING  = 6'h01;
    localparam logic [5:0] ADDR_STATUS0 = 6'h04;
    localparam logic [5:0] ADDR_CMD0    = 6'h05;
    localparam logic [5:0] ADDR_TARGET0 = 6'h06;
    localparam logic [5:0] ADDR_STATUS1 = 6'h0C;
    localparam logic [5:0] ADDR_CMD1    = 6'h0D;
    localparam logic [5:0] ADDR_TARGET1 = 6'h0E;

    //----------------------------------------------------------
    // Bit positions
    //----------------------------------------------------------
    localparam int CTRL_DRIVE_SEL = 8;          // 0 = drive 0, 1 = drive 1
    localparam int CTRL_DRV0_EN   = 16;
    localparam int CTRL_DRV1_EN   = 17;

    localparam int CMD_SEEK     = 0;
    localparam int CMD_RECAL    = 1;
    localparam int CMD_HEAD_LSB = 4;            // 4-bit head field base

    localparam int STAT_BUSY    = 8;
    localparam int STAT_DONE    = 9;
    localparam int STAT_ERROR   = 10;
    localparam int STAT_CYL_LSB = 16;           // Cylinder in 31:16
    // Bits 4:0 carry the drive lines: ready, seek cmpl, track 0, wfault, index

    // Step width 10 cycles in 7:0, step period 40 cycles in 23:8
    localparam logic [31:0] TIMING_RESET = {8'h00, 16'd40, 8'd10};

    // Defaults for the top level parameters
    localparam int DEF_SEEK_TIMEOUT    = 1_000_000;
    localparam int DEF_MAX_RECAL_STEPS = 1024;

endpackage

`default_nettype wire
